// File: design/exu_cluster_top.sv
module exu_cluster_top #(
  parameter int unsigned NUM_LANES = 4
) (
  input  logic              clk,
  input  logic              rst_n_i,
  input  logic              op_valid_i,
  input  exu_pkg::exu_op_t  op_i,
  output logic              issue_ready_o,
  output logic              res_valid_o,
  output exu_pkg::exu_res_t res_o
);

  import exu_pkg::*;

  logic [NUM_LANES-1:0] lane_start;
  logic [NUM_LANES-1:0] lane_busy;
  logic [NUM_LANES-1:0] lane_done;
  lane_req_t            lane_req;
  lane_res_t            lane_res [NUM_LANES];
  logic                 retire;

  exu_dispatch #(
    .NUM_LANES (NUM_LANES)
  ) u_dispatch (
    .clk           (clk),
    .rst_n_i       (rst_n_i),
    .op_valid_i    (op_valid_i),
    .op_i          (op_i),
    .lane_busy_i   (lane_busy),
    .retire_i      (retire),
    .issue_ready_o (issue_ready_o),
    .lane_start_o  (lane_start),
    .lane_req_o    (lane_req)
  );

  // identical lanes share one request bus, start picks the lane
  for (genvar g = 0; g < NUM_LANES; g++) begin : g_lane
    exu_lane u_lane (
      .clk     (clk),
      .rst_n_i (rst_n_i),
      .start_i (lane_start[g]),
      .req_i   (lane_req),
      .busy_o  (lane_busy[g]),
      .done_o  (lane_done[g]),
      .res_o   (lane_res[g])
    );
  end

  exu_collect #(
    .NUM_LANES (NUM_LANES)
  ) u_collect (
    .clk         (clk),
    .rst_n_i     (rst_n_i),
    .lane_done_i (lane_done),
    .lane_res_i  (lane_res),
    .retire_o    (retire),
    .res_valid_o (res_valid_o),
    .res_o       (res_o)
  );

endmodule

// File: design/exu_collect.sv
module exu_collect #(
  parameter int unsigned NUM_LANES = 4
) (
  input  logic                 clk,
  input  logic                 rst_n_i,
  input  logic [NUM_LANES-1:0] lane_done_i,
  input  exu_pkg::lane_res_t   lane_res_i [NUM_LANES],
  output logic                 retire_o,
  output logic                 res_valid_o,
  output exu_pkg::exu_res_t    res_o
);

  import exu_pkg::*;

  logic [NUM_LANES-1:0] slot_vld_q;
  lane_res_t            slot_q [NUM_LANES];
  tag_t                 exp_tag_q;

  // slot contents, or the lane output in its done cycle
  logic [NUM_LANES-1:0] cand_vld;
  lane_res_t            cand [NUM_LANES];

  logic                 hit;
  logic [NUM_LANES-1:0] sel_oh;
  exu_res_t             sel_res;

  logic                 out_vld_q;
  exu_res_t             out_res_q;

  always_comb begin
    for (int i = 0; i < NUM_LANES; i++) begin
      cand_vld[i] = slot_vld_q[i] | lane_done_i[i];
      cand[i]     = slot_vld_q[i] ? slot_q[i] : lane_res_i[i];
    end
  end

  // find the result carrying the next tag in order
  always_comb begin
    hit     = 1'b0;
    sel_oh  = '0;
    sel_res = '0;
    for (int i = 0; i < NUM_LANES; i++) begin
      if (!hit && cand_vld[i] && (cand[i].tag == exp_tag_q)) begin
        hit       = 1'b1;
        sel_oh[i] = 1'b1;
        sel_res   = cand[i].res;
      end
    end
  end

  always_ff @(posedge clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      slot_vld_q <= '0;
      exp_tag_q  <= '0;
      out_vld_q  <= 1'b0;
    end else begin
      out_vld_q <= hit;
      if (hit) begin
        exp_tag_q <= exp_tag_q + 1'b1;
      end
      for (int i = 0; i < NUM_LANES; i++) begin
        if (sel_oh[i]) begin
          slot_vld_q[i] <= 1'b0;
        end else if (lane_done_i[i]) begin
          slot_vld_q[i] <= 1'b1;
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    for (int i = 0; i < NUM_LANES; i++) begin
      if (lane_done_i[i]) begin
        slot_q[i] <= lane_res_i[i];
      end
    end
    if (hit) begin
      out_res_q <= sel_res;
    end
  end

  // every emitted result frees one outstanding op
  assign retire_o    = out_vld_q;
  assign res_valid_o = out_vld_q;
  assign res_o       = out_res_q;

endmodule

// File: design/exu_dispatch.sv
module exu_dispatch #(
  parameter int unsigned NUM_LANES = 4
) (
  input  logic                   clk,
  input  logic                   rst_n_i,
  input  logic                   op_valid_i,
  input  exu_pkg::exu_op_t       op_i,
  input  logic [NUM_LANES-1:0]   lane_busy_i,
  input  logic                   retire_i,
  output logic                   issue_ready_o,
  output logic [NUM_LANES-1:0]   lane_start_o,
  output exu_pkg::lane_req_t     lane_req_o
);

  import exu_pkg::*;

  tag_t                 tag_q;
  tag_t                 ret_tag_q;
  logic [3:0]           outstanding_q;
  // lanes holding an op whose result has not retired yet
  logic [NUM_LANES-1:0] owned_q;
  logic [NUM_LANES-1:0] free_lanes;
  logic [NUM_LANES-1:0] pick;
  logic [NUM_LANES-1:0] ret_mask;
  logic                 issue;

  // lane that ran each tag, read back in retire order
  logic [NUM_LANES-1:0] tag_lane_q [2**TAG_W];

  assign free_lanes = ~(owned_q | lane_busy_i);

  // lowest index wins
  always_comb begin
    pick = '0;
    for (int i = NUM_LANES - 1; i >= 0; i--) begin
      if (free_lanes[i]) begin
        pick    = '0;
        pick[i] = 1'b1;
      end
    end
  end

  assign issue_ready_o = (|free_lanes) && (outstanding_q < 4'(NUM_LANES));
  assign issue         = op_valid_i && issue_ready_o;
  assign ret_mask      = retire_i ? tag_lane_q[ret_tag_q] : '0;

  always_ff @(posedge clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      lane_start_o  <= '0;
      tag_q         <= '0;
      ret_tag_q     <= '0;
      outstanding_q <= '0;
      owned_q       <= '0;
    end else begin
      lane_start_o <= issue ? pick : '0;
      owned_q      <= (owned_q & ~ret_mask) | (issue ? pick : '0);
      if (issue) begin
        tag_q <= tag_q + 1'b1;
      end
      if (retire_i) begin
        ret_tag_q <= ret_tag_q + 1'b1;
      end
      case ({issue, retire_i})
        2'b10:   outstanding_q <= outstanding_q + 1'b1;
        2'b01:   outstanding_q <= outstanding_q - 1'b1;
        default: outstanding_q <= outstanding_q;
      endcase
    end
  end

  // request payload and tag table
  always_ff @(posedge clk) begin
    if (issue) begin
      lane_req_o        <= '{op: op_i, tag: tag_q};
      tag_lane_q[tag_q] <= pick;
    end
  end

endmodule

// File: design/exu_lane.sv
module exu_lane (
  input  logic               clk,
  input  logic               rst_n_i,
  input  logic               start_i,
  input  exu_pkg::lane_req_t req_i,
  output logic               busy_o,
  output logic               done_o,
  output exu_pkg::lane_res_t res_o
);

  import exu_pkg::*;

  lane_state_e state_q;
  lane_req_t   req_q;
  lane_req_t   cur_req;
  exu_op_t     op;
  xlen_t       shv_q;
  logic [1:0]  steps_q;
  exu_res_t    res_c;
  lane_res_t   res_q;

  logic        is_alu;
  logic        is_bjp;
  logic        is_ls;
  logic        is_shift;
  logic        long_shift;
  logic        accept;
  logic        finish;

  logic        use_sub;
  logic        cmp_unsigned;
  logic [XLEN:0] add_a;
  logic [XLEN:0] add_b;
  logic [XLEN:0] sum;
  logic        lt;
  logic        eq;

  xlen_t       sh_src;
  logic [4:0]  sh_amt;
  xlen_t       sh_out;
  xlen_t       alu_val;

  // held request while shifting, live request otherwise
  assign cur_req = (state_q == SHIFT) ? req_q : req_i;
  assign op      = cur_req.op;

  assign is_alu     = (op.unit == ALU);
  assign is_bjp     = (op.unit == BJP);
  assign is_ls      = (op.unit == LS);
  assign is_shift   = is_alu && (op.alu_op inside {SLL, SRL, SRA});
  // more than 15 bits needs extra steps
  assign long_shift = is_shift && (op.op2[5:4] != 2'd0);

  assign accept = start_i && (state_q != SHIFT);
  assign finish = (accept && !long_shift) || (state_q == SHIFT && steps_q == 2'd1);

  // shared 65 bit adder, also the comparator
  assign use_sub = (is_alu && (op.alu_op inside {SUB, SLT, SLTU})) ||
                   (is_bjp && !(op.bjp_op inside {JAL, JALR}));
  assign cmp_unsigned = (is_alu && op.alu_op == SLTU) ||
                        (is_bjp && (op.bjp_op inside {BLTU, BGEU}));

  assign add_a = {(cmp_unsigned ? 1'b0 : op.op1[XLEN-1]), op.op1};
  assign add_b = {(cmp_unsigned ? 1'b0 : op.op2[XLEN-1]), op.op2};
  assign sum   = add_a + (use_sub ? ~add_b : add_b) + {{XLEN{1'b0}}, use_sub};
  assign lt    = sum[XLEN];
  assign eq    = (sum[XLEN-1:0] == '0);

  // first step takes shamt[3:0], later steps 16 bits each
  assign sh_src = (state_q == SHIFT) ? shv_q : op.op1;
  assign sh_amt = (state_q == SHIFT) ? 5'd16 : {1'b0, op.op2[3:0]};

  always_comb begin
    case (op.alu_op)
      SLL:     sh_out = sh_src << sh_amt;
      SRL:     sh_out = sh_src >> sh_amt;
      SRA:     sh_out = xlen_t'($signed(sh_src) >>> sh_amt);
      default: sh_out = sh_src;
    endcase
  end

  always_comb begin
    case (op.alu_op)
      ADD, SUB:      alu_val = sum[XLEN-1:0];
      SLT, SLTU:     alu_val = {{(XLEN-1){1'b0}}, lt};
      XOR:           alu_val = op.op1 ^ op.op2;
      OR:            alu_val = op.op1 | op.op2;
      AND:           alu_val = op.op1 & op.op2;
      SLL, SRL, SRA: alu_val = sh_out;
      LUI:           alu_val = op.op2;
      default:       alu_val = '0;
    endcase
  end

  always_comb begin
    res_c.rd_wr_en  = op.rd_wr_en;
    res_c.rd_idx    = op.rd_idx;
    // jumps and memory ops give op1 + op2, branches op1 - op2
    res_c.alu_res   = is_alu ? alu_val : sum[XLEN-1:0];
    res_c.ls_info   = is_ls ? op.ls_info : '0;
    res_c.rs2_store = (is_ls && op.ls_info.store) ? op.op2_jp : '0;
    res_c.jump_addr = op.op1_jp + op.op2_jp;
    res_c.ebreak    = is_alu && (op.alu_op == EBREAK);
    res_c.invalid   = op.invalid;
    res_c.jump_flag = 1'b0;
    if (is_bjp) begin
      case (op.bjp_op)
        JAL, JALR:  res_c.jump_flag = 1'b1;
        BEQ:        res_c.jump_flag = eq;
        BNE:        res_c.jump_flag = !eq;
        BLT, BLTU:  res_c.jump_flag = lt;
        default:    res_c.jump_flag = !lt;
      endcase
    end
  end

  always_ff @(posedge clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      state_q <= IDLE;
      steps_q <= '0;
    end else begin
      case (state_q)
        SHIFT: begin
          steps_q <= steps_q - 1'b1;
          if (steps_q == 2'd1) begin
            state_q <= DONE;
          end
        end
        default: begin
          if (start_i) begin
            state_q <= long_shift ? SHIFT : DONE;
            steps_q <= op.op2[5:4];
          end else begin
            state_q <= IDLE;
          end
        end
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (accept) begin
      req_q <= req_i;
    end
    if (accept || state_q == SHIFT) begin
      shv_q <= sh_out;
    end
    if (finish) begin
      res_q <= '{res: res_c, tag: cur_req.tag};
    end
  end

  assign busy_o = (state_q != IDLE);
  assign done_o = (state_q == DONE);
  assign res_o  = res_q;

endmodule

// File: design/exu_pkg.sv
package exu_pkg;

  // datapath and issue tag widths
  localparam int XLEN  = 64;
  localparam int TAG_W = 4;

  typedef logic [XLEN-1:0]  xlen_t;
  typedef logic [4:0]       reg_idx_t;
  // issue sequence number, wraps at 16
  typedef logic [TAG_W-1:0] tag_t;

  // execute unit select
  typedef enum logic [1:0] {
    ALU,
    BJP,
    LS
  } unit_e;

  typedef enum logic [3:0] {
    ADD,
    SUB,
    SLL,
    SLT,
    SLTU,
    XOR,
    SRL,
    SRA,
    OR,
    AND,
    LUI,
    EBREAK
  } alu_op_e;

  typedef enum logic [2:0] {
    JAL,
    JALR,
    BEQ,
    BNE,
    BLT,
    BGE,
    BLTU,
    BGEU
  } bjp_op_e;

  // access size and kind, msb first as on the old info bus
  typedef struct packed {
    logic dw;
    logic word;
    logic db;
    logic bt;     // single byte access
    logic usign;
    logic store;
    logic load;
  } ls_info_t;

  // one decoded operation
  typedef struct packed {
    unit_e    unit;
    alu_op_e  alu_op;
    bjp_op_e  bjp_op;
    ls_info_t ls_info;
    logic     rd_wr_en;
    reg_idx_t rd_idx;
    xlen_t    op1;
    xlen_t    op2;
    xlen_t    op1_jp;
    xlen_t    op2_jp;
    logic     invalid;
  } exu_op_t;

  // one execute result
  typedef struct packed {
    logic     rd_wr_en;
    reg_idx_t rd_idx;
    xlen_t    alu_res;
    ls_info_t ls_info;
    xlen_t    rs2_store;
    logic     jump_flag;
    xlen_t    jump_addr;
    logic     ebreak;
    logic     invalid;
  } exu_res_t;

  typedef struct packed {
    exu_op_t op;
    tag_t    tag;
  } lane_req_t;

  typedef struct packed {
    exu_res_t res;
    tag_t     tag;
  } lane_res_t;

  // lane FSM
  typedef enum logic [1:0] {
    IDLE,
    SHIFT,
    DONE
  } lane_state_e;

endpackage

// File: sim.f
+incdir+testbench
design/exu_pkg.sv
design/exu_dispatch.sv
design/exu_lane.sv
design/exu_collect.sv
design/exu_cluster_top.sv
testbench/tb_exu_cluster.sv

// File: testbench/tb_exu_model.svh
// expected result of one op, standard RISC-V 64-bit semantics
function automatic exu_res_t model_exec(input exu_op_t op);
  exu_res_t   r;
  logic [5:0] shamt;
  r           = '0;
  shamt       = op.op2[5:0];
  r.rd_wr_en  = op.rd_wr_en;
  r.rd_idx    = op.rd_idx;
  r.invalid   = op.invalid;
  r.jump_addr = op.op1_jp + op.op2_jp;
  case (op.unit)
    ALU: begin
      case (op.alu_op)
        ADD:     r.alu_res = op.op1 + op.op2;
        SUB:     r.alu_res = op.op1 - op.op2;
        SLL:     r.alu_res = op.op1 << shamt;
        SLT:     r.alu_res = ($signed(op.op1) < $signed(op.op2)) ? 64'd1 : 64'd0;
        SLTU:    r.alu_res = (op.op1 < op.op2) ? 64'd1 : 64'd0;
        XOR:     r.alu_res = op.op1 ^ op.op2;
        SRL:     r.alu_res = op.op1 >> shamt;
        SRA:     r.alu_res = $signed(op.op1) >>> shamt;
        OR:      r.alu_res = op.op1 | op.op2;
        AND:     r.alu_res = op.op1 & op.op2;
        LUI:     r.alu_res = op.op2;
        default: r.ebreak  = 1'b1;
      endcase
    end
    BJP: begin
      // link add for jumps, compare difference for branches
      r.alu_res = (op.bjp_op inside {JAL, JALR}) ? op.op1 + op.op2 : op.op1 - op.op2;
      case (op.bjp_op)
        BEQ:     r.jump_flag = (op.op1 == op.op2);
        BNE:     r.jump_flag = (op.op1 != op.op2);
        BLT:     r.jump_flag = ($signed(op.op1) < $signed(op.op2));
        BGE:     r.jump_flag = ($signed(op.op1) >= $signed(op.op2));
        BLTU:    r.jump_flag = (op.op1 < op.op2);
        BGEU:    r.jump_flag = (op.op1 >= op.op2);
        default: r.jump_flag = 1'b1;
      endcase
    end
    default: begin
      r.alu_res = op.op1 + op.op2;
      r.ls_info = op.ls_info;
      if (op.ls_info.store) begin
        r.rs2_store = op.op2_jp;
      end
    end
  endcase
  return r;
endfunction

// random decoded op, biased toward ALU ops and long shifts
function automatic exu_op_t gen_op();
  exu_op_t     op;
  logic [31:0] r;
  logic [31:0] r2;
  r           = $random(seed);
  r2          = $random(seed);
  op          = '0;
  op.unit     = unit_e'((r[1:0] == 2'd3) ? 2'd0 : r[1:0]);
  op.alu_op   = alu_op_e'(r[7:4] % 4'd12);
  op.bjp_op   = bjp_op_e'(r[10:8]);
  op.ls_info  = ls_info_t'(r[17:11]);
  op.rd_wr_en = r[18];
  op.rd_idx   = r[23:19];
  op.invalid  = (r[31:29] == 3'd0);
  op.op1      = {$random(seed), $random(seed)};
  op.op2      = {$random(seed), $random(seed)};
  op.op1_jp   = {$random(seed), $random(seed)};
  op.op2_jp   = {$random(seed), $random(seed)};
  // equal operands so beq and bge hit both ways
  if (r2[7:6] == 2'd0) begin
    op.op2 = op.op1;
  end
  if (r2[1:0] == 2'd0) begin
    op.unit       = ALU;
    op.alu_op     = r2[3] ? SRA : (r2[2] ? SRL : SLL);
    op.op2[5:4]   = (r2[5:4] == 2'd0) ? 2'd3 : r2[5:4];
  end
  return op;
endfunction

// File: testbench/tb_exu_cluster.sv
module tb_exu_cluster;

  import exu_pkg::*;

  localparam int unsigned NUM_LANES = 4;
  localparam int          NUM_OPS   = 400;
  localparam int          TIMEOUT   = 200;
  localparam int          DRIVE_DLY = 2;

  logic     clk;
  logic     rst_n_i;
  logic     op_valid_i;
  exu_op_t  op_i;
  logic     issue_ready_o;
  logic     res_valid_o;
  exu_res_t res_o;

  integer   seed;
  exu_res_t exp_q [$];
  exu_res_t exp_res;
  int       n_checked;

  `include "tb_exu_model.svh"

  exu_cluster_top #(
    .NUM_LANES (NUM_LANES)
  ) u_dut (
    .clk           (clk),
    .rst_n_i       (rst_n_i),
    .op_valid_i    (op_valid_i),
    .op_i          (op_i),
    .issue_ready_o (issue_ready_o),
    .res_valid_o   (res_valid_o),
    .res_o         (res_o)
  );

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  task automatic compare_value(input string name, input logic [63:0] expected,
                               input logic [63:0] actual);
    if (expected !== actual) begin
      $display("ERR %s expected %h actual %h", name, expected, actual);
      $display("Simulation failed");
      $fatal(1, "value mismatch");
    end
  endtask

  task automatic compare_result(input exu_res_t exp, input exu_res_t act);
    string id;
    id = $sformatf("op %0d", n_checked);
    compare_value({id, " rd_wr_en"}, exp.rd_wr_en, act.rd_wr_en);
    compare_value({id, " rd_idx"}, exp.rd_idx, act.rd_idx);
    compare_value({id, " alu_res"}, exp.alu_res, act.alu_res);
    compare_value({id, " ls_info"}, exp.ls_info, act.ls_info);
    compare_value({id, " rs2_store"}, exp.rs2_store, act.rs2_store);
    compare_value({id, " jump_flag"}, exp.jump_flag, act.jump_flag);
    compare_value({id, " jump_addr"}, exp.jump_addr, act.jump_addr);
    compare_value({id, " ebreak"}, exp.ebreak, act.ebreak);
    compare_value({id, " invalid"}, exp.invalid, act.invalid);
  endtask

  task automatic wait_issue_ready();
    int cycles;
    cycles = 0;
    while (!issue_ready_o && cycles < TIMEOUT) begin
      @(posedge clk);
      #DRIVE_DLY;
      cycles++;
    end
    if (!issue_ready_o) begin
      $display("timeout while waiting for issue_ready_o");
      $display("Simulation failed");
      $fatal(1, "timeout");
    end
  endtask

  task automatic wait_drain();
    int cycles;
    cycles = 0;
    while (exp_q.size() != 0 && cycles < TIMEOUT) begin
      @(posedge clk);
      cycles++;
    end
    if (exp_q.size() != 0) begin
      $display("timeout while waiting for outstanding results");
      $display("Simulation failed");
      $fatal(1, "timeout");
    end
  endtask

  // outputs are registered, so look at them mid cycle
  always @(negedge clk) begin
    if (rst_n_i && res_valid_o) begin
      if (exp_q.size() == 0) begin
        $display("result came out with no op outstanding");
        $display("Simulation failed");
        $fatal(1, "unexpected result");
      end else begin
        exp_res = exp_q.pop_front();
        compare_result(exp_res, res_o);
        n_checked++;
      end
    end
  end

  initial begin
    seed       = 86;
    n_checked  = 0;
    rst_n_i    = 1'b0;
    op_valid_i = 1'b0;
    op_i       = '0;
    repeat (8) @(posedge clk);
    #DRIVE_DLY;
    rst_n_i = 1'b1;
    @(posedge clk);
    #DRIVE_DLY;
    compare_value("reset res_valid_o", 64'd0, res_valid_o);
    compare_value("reset issue_ready_o", 64'd1, issue_ready_o);

    // back to back whenever the cluster can take an op
    for (int i = 0; i < NUM_OPS; i++) begin
      wait_issue_ready();
      op_i       = gen_op();
      op_valid_i = 1'b1;
      exp_q.push_back(model_exec(op_i));
      @(posedge clk);
      #DRIVE_DLY;
      op_valid_i = 1'b0;
    end

    wait_drain();
    repeat (4) @(posedge clk);
    if (n_checked == NUM_OPS && exp_q.size() == 0) begin
      $display("Simulation passed");
      $finish;
    end else begin
      $display("result count is %0d, not %0d", n_checked, NUM_OPS);
      $display("Simulation failed");
      $fatal(1, "lost results");
    end
  end

endmodule
